// ==== Makefile ====
# Verilator build and run of the CPU write path testbench.

SIM  = obj_dir/Vtb_vga_mem_wr
SRCS = $(shell grep -v '^+' verilog.f) verilog/vga_mem_defines.svh

all: run

# rebuilt only when the file list or a source is newer than the binary
$(SIM): verilog.f $(SRCS)
	verilator --binary -Wno-fatal -f verilog.f --top-module tb_vga_mem_wr

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== verification/tb_vga_mem_wr.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module tb_vga_mem_wr;

  typedef enum logic [1:0] {
    ROW_PUSH,
    ROW_IDLE,
    ROW_CRT_ON,
    ROW_CRT_OFF
  } row_kind_e;

  typedef struct packed {
    row_kind_e              kind;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
    logic [7:0]             cycles; // idle rows only.
  } stim_row_t;

  localparam int DRAIN_LIMIT = `CPU_FIFO_DEPTH * (`MEM_WR_LAT + 5) + `CRT_SLOT + 20;

  logic                   mem_clk;
  logic                   hreset_n;
  logic                   wr_valid;
  logic [`MEM_ADDR_W-1:0] wr_addr;
  logic [`MEM_DATA_W-1:0] wr_data;
  logic                   crt_req;
  logic                   fifo_full;
  logic                   crt_gnt;
  logic                   mem_we;
  logic [`MEM_ADDR_W-1:0] mem_addr;
  logic [`MEM_DATA_W-1:0] mem_data;
  logic                   drain_done;
  int                     error_count;
  int                     pending;
  integer                 seed;
  int                     cycle_count;
  int                     cycle_limit = 0;
  stim_row_t              stim_q[$];

  vga_mem_wr_top dut_i (.*);

  vga_mem_wr_checker u_checker (.*);

  initial mem_clk = 1'b0;
  always #2 mem_clk = ~mem_clk;

  task automatic next_cycle();
    @(posedge mem_clk);
    #1;
  endtask

  task automatic add_row(input row_kind_e kind, input logic [`MEM_ADDR_W-1:0] addr,
                         input logic [`MEM_DATA_W-1:0] data, input int cycles);
    stim_row_t row;
    row.kind   = kind;
    row.addr   = addr;
    row.data   = data;
    row.cycles = 8'(cycles);
    stim_q.push_back(row);
  endtask

  task automatic add_random_pushes(input int n);
    repeat (n) begin
      add_row(ROW_PUSH, `MEM_ADDR_W'($random(seed)), `MEM_DATA_W'($random(seed)), 0);
    end
  endtask

  task automatic build_table();
    add_row(ROW_PUSH, 16'h0010, 32'hdead_beef, 0);
    add_row(ROW_IDLE, '0, '0, 10);
    add_random_pushes(3);
    add_row(ROW_CRT_ON, '0, '0, 0);
    add_row(ROW_IDLE, '0, '0, 3);
    add_random_pushes(4); // at most 7 queued while refresh starves the cpu.
    add_row(ROW_IDLE, '0, '0, 12);
    add_row(ROW_CRT_OFF, '0, '0, 0);
    add_random_pushes(12); // outruns the drain and fills the fifo.
    add_row(ROW_IDLE, '0, '0, 4);
    add_row(ROW_CRT_ON, '0, '0, 0);
    add_row(ROW_PUSH, 16'h003f, 32'h1234_5678, 0);
    add_row(ROW_CRT_OFF, '0, '0, 0);
    add_row(ROW_PUSH, 16'hffc0, 32'h0bad_cafe, 0);
    add_row(ROW_IDLE, '0, '0, 6);
  endtask

  function automatic int run_limit();
    int limit;
    limit = 8 + DRAIN_LIMIT + 50;
    foreach (stim_q[i]) begin
      limit += stim_q[i].cycles + 1 + `MEM_WR_LAT + 2 + `CRT_SLOT;
    end
    return limit;
  endfunction

  task automatic apply_row(input stim_row_t row);
    case (row.kind)
      ROW_PUSH: begin
        while (fifo_full) next_cycle(); // hold the write back while full.
        wr_valid = 1'b1;
        wr_addr  = row.addr;
        wr_data  = row.data;
        next_cycle();
        wr_valid = 1'b0;
      end
      ROW_IDLE: repeat (row.cycles) next_cycle();
      ROW_CRT_ON: begin
        crt_req = 1'b1;
        next_cycle();
      end
      ROW_CRT_OFF: begin
        crt_req = 1'b0;
        next_cycle();
      end
      default: next_cycle();
    endcase
  endtask

  initial begin : watchdog
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge mem_clk);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", cycle_limit);
    $display("errors: %0d from checks, 1 timeout", error_count);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    int drain_wait;
    seed       = 84193;
    hreset_n   = 1'b0;
    wr_valid   = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    crt_req    = 1'b0;
    drain_done = 1'b0;
    build_table();
    cycle_limit = run_limit();
    repeat (8) @(posedge mem_clk);
    #1;
    hreset_n = 1'b1;
    next_cycle();
    foreach (stim_q[i]) begin
      apply_row(stim_q[i]);
    end
    drain_wait = 0;
    while (pending != 0 && drain_wait < DRAIN_LIMIT) begin
      next_cycle();
      drain_wait++;
    end
    repeat (4) next_cycle(); // let the last pop land.
    drain_done = 1'b1;
    repeat (2) next_cycle();
    $display("errors: %0d from checks, 0 timeouts", error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/vga_mem_wr_checker.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module vga_mem_wr_checker (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  logic                   wr_valid,
  input  logic [`MEM_ADDR_W-1:0] wr_addr,
  input  logic [`MEM_DATA_W-1:0] wr_data,
  input  logic                   crt_req,
  input  logic                   fifo_full,
  input  logic                   crt_gnt,
  input  logic                   mem_we,
  input  logic [`MEM_ADDR_W-1:0] mem_addr,
  input  logic [`MEM_DATA_W-1:0] mem_data,
  input  logic                   drain_done,
  output int                     error_count,
  output int                     pending
);

  import vga_mem_pkg::*;

  wr_entry_t exp_q[$]; // accepted, not yet committed.
  wr_entry_t entry;
  int        errors = 0;
  int        unpopped;  // accepted, not yet popped from the fifo.
  int        gnt_len;
  logic      pop_due;
  logic      crt_req_q;
  logic      crt_gnt_q;
  logic      first_cycle;
  logic      drain_checked;

  assign error_count = errors;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic check_quiet();
    if (mem_we !== 1'b0) report_mismatch("mem_we", 0, mem_we);
    if (crt_gnt !== 1'b0) report_mismatch("crt_gnt", 0, crt_gnt);
    if (fifo_full !== 1'b0) report_mismatch("fifo_full", 0, fifo_full);
  endtask

  // sampled mid cycle, away from both the clock edge and the input changes.
  always @(negedge mem_clk) begin
    if (!hreset_n) begin
      exp_q.delete();
      unpopped      = 0;
      gnt_len       = 0;
      pop_due       = 1'b0;
      crt_req_q     = 1'b0;
      crt_gnt_q     = 1'b0;
      first_cycle   = 1'b1;
      drain_checked = 1'b0;
      check_quiet();
    end else begin
      if (first_cycle) begin
        check_quiet();
        first_cycle = 1'b0;
      end
      if (fifo_full !== (unpopped == `CPU_FIFO_DEPTH)) begin
        report_mismatch("fifo_full", unpopped == `CPU_FIFO_DEPTH, fifo_full);
      end
      if (mem_we && crt_gnt) report_failure("mem_we pulsed while the CRT owned the bus");
      if (mem_we) begin
        if (exp_q.size() == 0) begin
          report_failure($sformatf("commit to 0x%0h with no pending write", mem_addr));
        end else begin
          entry = exp_q.pop_front();
          if (mem_addr !== entry.addr) report_mismatch("mem_addr", entry.addr, mem_addr);
          if (mem_data !== entry.data) report_mismatch("mem_data", entry.data, mem_data);
        end
      end
      if (crt_gnt && !crt_gnt_q && !crt_req_q) report_failure("crt_gnt rose without a CRT request");
      if (crt_gnt) begin
        gnt_len++;
        if (gnt_len == `CRT_SLOT + 1) report_failure("crt_gnt held past its slot");
      end else if (crt_gnt_q) begin
        if (gnt_len != `CRT_SLOT) report_mismatch("crt_gnt length", `CRT_SLOT, gnt_len);
        gnt_len = 0;
      end
      if (wr_valid && unpopped != `CPU_FIFO_DEPTH) begin
        entry.addr = wr_addr;
        entry.data = wr_data;
        exp_q.push_back(entry);
        unpopped++;
      end
      if (pop_due) unpopped--; // the pop lands the cycle after the commit.
      pop_due   = mem_we;
      crt_req_q = crt_req;
      crt_gnt_q = crt_gnt;
      if (drain_done && !drain_checked) begin
        drain_checked = 1'b1;
        foreach (exp_q[i]) begin
          report_failure($sformatf("write to 0x%0h with data 0x%0h never committed",
                                   exp_q[i].addr, exp_q[i].data));
        end
        if (unpopped != 0) begin
          report_failure($sformatf("fifo still holds %0d entries after the drain", unpopped));
        end
      end
    end
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/vga_mem_pkg.sv
verilog/mem_wr_if.sv
verilog/cpu_wr_fifo.sv
verilog/sm_cpuwr.sv
verilog/mem_arbiter.sv
verilog/svga_mem_port.sv
verilog/vga_mem_wr_top.sv
verification/vga_mem_wr_checker.sv
verification/tb_vga_mem_wr.sv

// ==== verilog/cpu_wr_fifo.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module cpu_wr_fifo (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  logic                   wr_valid,
  input  logic [`MEM_ADDR_W-1:0] wr_addr,
  input  logic [`MEM_DATA_W-1:0] wr_data,
  output logic                   fifo_full,
  mem_wr_if.fifo_mp              bus
);

  import vga_mem_pkg::*;

  localparam int PTR_W = $clog2(`CPU_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  wr_entry_t        fifo_mem [`CPU_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign push = wr_valid & ~fifo_full; // writes while full are lost.
  assign pop  = bus.fifo_read & bus.wr_pend;

  assign bus.wr_pend = (count != '0);
  assign fifo_full   = (count == CNT_W'(`CPU_FIFO_DEPTH));
  assign bus.head    = fifo_mem[rd_ptr];

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two.
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge mem_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= '{addr: wr_addr, data: wr_data};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module mem_arbiter (
  input  logic mem_clk,
  input  logic hreset_n,
  input  logic cpu_wr_req,
  input  logic cpu_arb_wr,
  input  logic crt_req,
  output logic cpu_wr_gnt,
  output logic crt_gnt
);

  import vga_mem_pkg::*;

  localparam int SLOT_W = $clog2(`CRT_SLOT);

  arb_owner_e        owner;
  logic [SLOT_W-1:0] slot_cnt;
  logic              cpu_done;

  assign cpu_done   = ~cpu_arb_wr & ~cpu_wr_req;
  assign cpu_wr_gnt = (owner == ARB_CPU);
  assign crt_gnt    = (owner == ARB_CRT);

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      owner    <= ARB_IDLE;
      slot_cnt <= '0;
    end else begin
      case (owner)
        ARB_IDLE: begin
          if (crt_req) begin // refresh wins a tie.
            owner    <= ARB_CRT;
            slot_cnt <= SLOT_W'(`CRT_SLOT - 1);
          end else if (cpu_wr_req) begin
            owner <= ARB_CPU;
          end
        end
        ARB_CPU: begin
          if (cpu_done) begin
            owner <= ARB_IDLE;
          end
        end
        ARB_CRT: begin
          if (slot_cnt == '0) begin
            owner <= ARB_IDLE; // slot over.
          end else begin
            slot_cnt <= slot_cnt - 1'b1;
          end
        end
        default: begin
          owner <= ARB_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_wr_if.sv ====
`default_nettype none
`timescale 1ns/1ns

interface mem_wr_if;

  import vga_mem_pkg::*;

  logic      wr_pend;   // fifo holds at least one write.
  wr_entry_t head;      // oldest posted write.
  logic      svga_req;  // held until svga_ack.
  logic      svga_ack;  // single cycle.
  logic      fifo_read; // pops head.

  modport fifo_mp (
    output wr_pend,
    output head,
    input  fifo_read
  );

  modport seq_mp (
    output svga_req,
    output fifo_read,
    input  wr_pend,
    input  svga_ack
  );

  modport mem_mp (
    output svga_ack,
    input  svga_req,
    input  head
  );

endinterface

`default_nettype wire

// ==== verilog/sm_cpuwr.sv ====
`default_nettype none
`timescale 1ns/1ns

module sm_cpuwr (
  input  logic      mem_clk,
  input  logic      hreset_n,
  input  logic      crt_req,
  input  logic      cpu_wr_gnt,
  output logic      cpu_wr_req,
  output logic      cpu_arb_wr,
  mem_wr_if.seq_mp  bus
);

  import vga_mem_pkg::*;

  cpuwr_state_e current_state;
  cpuwr_state_e next_state;
  logic         int_svga_req;
  logic         en_fifo_read;
  logic         release_bus;

  assign release_bus = ~bus.wr_pend | crt_req; // refresh waiting or nothing left.

  assign bus.svga_req  = int_svga_req & bus.wr_pend;
  assign bus.fifo_read = en_fifo_read & bus.wr_pend;

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      current_state <= CPUWR_IDLE;
    end else begin
      current_state <= next_state;
    end
  end

  always_comb begin
    next_state   = current_state;
    cpu_wr_req   = 1'b0;
    cpu_arb_wr   = 1'b0;
    int_svga_req = 1'b0;
    en_fifo_read = 1'b0;
    case (current_state)
      CPUWR_IDLE: begin
        if (bus.wr_pend) begin
          next_state = CPUWR_REQ;
        end
      end
      CPUWR_REQ: begin
        cpu_wr_req = 1'b1;
        if (cpu_wr_gnt) begin
          next_state = CPUWR_SVGA;
        end
      end
      CPUWR_SVGA: begin
        cpu_wr_req   = 1'b1;
        cpu_arb_wr   = 1'b1;
        int_svga_req = 1'b1; // wait here through the memory latency.
        if (bus.svga_ack) begin
          next_state = CPUWR_POP;
        end
      end
      CPUWR_POP: begin
        cpu_wr_req   = 1'b1;
        cpu_arb_wr   = 1'b1;
        en_fifo_read = 1'b1;
        next_state   = CPUWR_HOLD;
      end
      CPUWR_HOLD: begin
        cpu_wr_req = 1'b1;
        cpu_arb_wr = 1'b1;
        if (release_bus) begin
          next_state = CPUWR_IDLE;
        end else begin
          next_state = CPUWR_SVGA; // keep the bus, no new arbitration.
        end
      end
      default: begin
        next_state = CPUWR_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/svga_mem_port.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module svga_mem_port (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  mem_wr_if.mem_mp               bus,
  output logic                   mem_we,
  output logic [`MEM_ADDR_W-1:0] mem_addr,
  output logic [`MEM_DATA_W-1:0] mem_data
);

  import vga_mem_pkg::*;

  localparam int CNT_W = $clog2(`MEM_WR_LAT + 1);

  logic [`MEM_DATA_W-1:0] mem_array [64];
  wr_entry_t              lat_entry;
  logic                   req_q;
  logic                   busy;
  logic [CNT_W-1:0]       lat_cnt;
  logic                   start;
  logic                   commit;
  logic                   ack_q;

  assign start  = bus.svga_req & ~req_q & ~busy; // rising edge of the request.
  assign commit = busy & (lat_cnt == CNT_W'(1));

  assign bus.svga_ack = ack_q;
  assign mem_we       = ack_q;
  assign mem_data     = mem_array[mem_addr[5:0]]; // reads back the word just written.

  always_ff @(posedge mem_clk or negedge hreset_n) begin
    if (!hreset_n) begin
      req_q   <= 1'b0;
      busy    <= 1'b0;
      lat_cnt <= '0;
      ack_q   <= 1'b0;
    end else begin
      req_q <= bus.svga_req;
      ack_q <= commit;
      if (start) begin
        busy    <= 1'b1;
        lat_cnt <= CNT_W'(`MEM_WR_LAT - 1);
      end else if (commit) begin
        busy    <= 1'b0;
        lat_cnt <= '0;
      end else if (busy) begin
        lat_cnt <= lat_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge mem_clk) begin
    if (start) begin
      lat_entry <= bus.head; // head as seen at request time.
    end
    if (commit) begin
      mem_array[lat_entry.addr[5:0]] <= lat_entry.data;
      mem_addr                       <= lat_entry.addr;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vga_mem_defines.svh ====
`ifndef VGA_MEM_DEFINES_SVH
`define VGA_MEM_DEFINES_SVH

// memory bus widths.
`define MEM_ADDR_W 16
`define MEM_DATA_W 32

// posted cpu writes, must be a power of two.
`define CPU_FIFO_DEPTH 8

// cycles from request rise to acknowledge.
`define MEM_WR_LAT 3

// length of one crt refresh grant.
`define CRT_SLOT 6

`endif

// ==== verilog/vga_mem_pkg.sv ====
`default_nettype none

package vga_mem_pkg;

  `include "vga_mem_defines.svh"

  // write sequencer states, encoded so neighbours differ in one bit.
  typedef enum logic [2:0] {
    CPUWR_IDLE = 3'b000,
    CPUWR_REQ  = 3'b001,
    CPUWR_SVGA = 3'b011,
    CPUWR_POP  = 3'b111,
    CPUWR_HOLD = 3'b110
  } cpuwr_state_e;

  typedef enum logic [1:0] {
    ARB_IDLE = 2'b00,
    ARB_CPU  = 2'b01,
    ARB_CRT  = 2'b10
  } arb_owner_e;

  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] data;
  } wr_entry_t;

endpackage

`default_nettype wire

// ==== verilog/vga_mem_wr_top.sv ====
`default_nettype none
`timescale 1ns/1ns

`include "vga_mem_defines.svh"

module vga_mem_wr_top (
  input  logic                   mem_clk,
  input  logic                   hreset_n,
  input  logic                   wr_valid,
  input  logic [`MEM_ADDR_W-1:0] wr_addr,
  input  logic [`MEM_DATA_W-1:0] wr_data,
  input  logic                   crt_req,
  output logic                   fifo_full,
  output logic                   crt_gnt,
  output logic                   mem_we,
  output logic [`MEM_ADDR_W-1:0] mem_addr,
  output logic [`MEM_DATA_W-1:0] mem_data
);

  logic cpu_wr_req;
  logic cpu_arb_wr;
  logic cpu_wr_gnt;

  mem_wr_if wr_bus ();

  cpu_wr_fifo u_fifo (
    .mem_clk   (mem_clk),
    .hreset_n  (hreset_n),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .fifo_full (fifo_full),
    .bus       (wr_bus.fifo_mp)
  );

  sm_cpuwr u_sm_cpuwr (
    .mem_clk    (mem_clk),
    .hreset_n   (hreset_n),
    .crt_req    (crt_req),
    .cpu_wr_gnt (cpu_wr_gnt),
    .cpu_wr_req (cpu_wr_req),
    .cpu_arb_wr (cpu_arb_wr),
    .bus        (wr_bus.seq_mp)
  );

  mem_arbiter u_arbiter (
    .mem_clk    (mem_clk),
    .hreset_n   (hreset_n),
    .cpu_wr_req (cpu_wr_req),
    .cpu_arb_wr (cpu_arb_wr),
    .crt_req    (crt_req),
    .cpu_wr_gnt (cpu_wr_gnt),
    .crt_gnt    (crt_gnt)
  );

  svga_mem_port u_mem_port (
    .mem_clk  (mem_clk),
    .hreset_n (hreset_n),
    .bus      (wr_bus.mem_mp),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_data (mem_data)
  );

endmodule

`default_nettype wire
